// ==== all.f ====
verilog/matrix_pkg.sv
verilog/elementwise_unit.sv
verilog/matmul_unit.sv
verilog/det_adj_unit.sv
verilog/result_select.sv
verilog/matrix_alu.sv
testbench/tb_clock_gen.sv
testbench/matrix_alu_props.sv
testbench/matrix_alu_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_alu

sources:
  - verilog/matrix_pkg.sv
  - verilog/elementwise_unit.sv
  - verilog/matmul_unit.sv
  - verilog/det_adj_unit.sv
  - verilog/result_select.sv
  - verilog/matrix_alu.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/matrix_alu_props.sv
      - testbench/matrix_alu_tb.sv

// ==== testbench/matrix_alu_tb.sv ====
`timescale 1ns/1ps

module matrix_alu_tb
    import matrix_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 40;            // Random starts per op
    localparam int N_CRAFT      = 6;             // Hand-made singular matrices
    localparam int N_BURST      = 14;            // Back-to-back starts
    // Isolated transactions take two cycles each
    localparam int N_SINGLE     = 3 * (N_RAND + 3) + 2 * N_RAND + N_RAND + 2 * N_CRAFT;
    localparam int PLANNED      = RESET_CYCLES + 2 * N_SINGLE + N_BURST + 6;
    localparam int TIMEOUT      = 2 * PLANNED;

    // Rows scaled or zeroed so the determinant is zero
    localparam logic [15:0] CRAFT [N_CRAFT] = '{
        16'h1224, 16'h844E, 16'h0000, 16'h3AF2, 16'h7777, 16'h050D
    };

    logic     clk;
    logic     reset;
    logic     start;
    op_t      op;
    mat_in_t  a;
    mat_in_t  b;
    elem_t    scalar;
    mat_out_t result;
    res_t     det;
    logic     singular;
    logic     done;

    logic [31:0] lfsr_state;                     // Galois LFSR state
    int          cycle_count;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    matrix_alu dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .op       (op),
        .a        (a),
        .b        (b),
        .scalar   (scalar),
        .result   (result),
        .det      (det),
        .singular (singular),
        .done     (done)
    );

    bind matrix_alu matrix_alu_props u_props (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .done     (done),
        .result   (result),
        .det      (det),
        .singular (singular)
    );

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic elem_t rand_elem();
        elem_t e;
        e = rand_bits(4);                        // Full range -8..7
        return e;
    endfunction

    function automatic mat_in_t rand_mat();
        mat_in_t m;
        m.m11 = rand_elem();
        m.m12 = rand_elem();
        m.m21 = rand_elem();
        m.m22 = rand_elem();
        return m;
    endfunction

    // Determinant from integer arithmetic
    function automatic int model_det(input mat_in_t x);
        return int'(x.m11) * int'(x.m22) - int'(x.m12) * int'(x.m21);
    endfunction

    // Expected matrix result per op
    function automatic mat_out_t model_result(input op_t o, input mat_in_t x,
                                              input mat_in_t y, input elem_t s);
        int       xv [4];                        // Order m11 m12 m21 m22
        int       yv [4];
        int       rv [4];
        int       sv;
        int       d;
        mat_out_t r;
        xv = '{x.m11, x.m12, x.m21, x.m22};
        yv = '{y.m11, y.m12, y.m21, y.m22};
        sv = s;
        d  = model_det(x);
        rv = '{0, 0, 0, 0};
        case (o)
            OP_ADD:       foreach (rv[i]) rv[i] = xv[i] + yv[i];
            OP_SUB:       foreach (rv[i]) rv[i] = xv[i] - yv[i];
            OP_SCALE:     foreach (rv[i]) rv[i] = sv * xv[i];
            OP_MUL: begin
                rv[0] = xv[0] * yv[0] + xv[1] * yv[2];
                rv[1] = xv[0] * yv[1] + xv[1] * yv[3];
                rv[2] = xv[2] * yv[0] + xv[3] * yv[2];
                rv[3] = xv[2] * yv[1] + xv[3] * yv[3];
            end
            OP_TRANSPOSE: rv = '{xv[0], xv[2], xv[1], xv[3]};
            OP_ADJ: begin
                if (d != 0) begin                // Zero matrix when singular
                    rv = '{xv[3], -xv[1], -xv[2], xv[0]};
                end
            end
            default: ;                           // OP_DET gives zeros
        endcase
        r.m11 = res_t'(rv[0]);
        r.m12 = res_t'(rv[1]);
        r.m21 = res_t'(rv[2]);
        r.m22 = res_t'(rv[3]);
        return r;
    endfunction

    task automatic fail_stop();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // Compare all outputs at a falling edge
    task automatic check_outputs(input string name, input mat_out_t er, input res_t ed,
                                 input logic es, input logic edone);
        assert (done === edone) else begin
            $display("ERR %s done expected %0b actual %0b", name, edone, done);
            fail_stop();
        end
        assert (result === er) else begin
            $display("ERR %s result expected %h actual %h", name, er, result);
            fail_stop();
        end
        assert (det === ed) else begin
            $display("ERR %s det expected %0d actual %0d", name, ed, det);
            fail_stop();
        end
        assert (singular === es) else begin
            $display("ERR %s singular expected %0b actual %0b", name, es, singular);
            fail_stop();
        end
    endtask

    // One isolated start followed by the done check
    task automatic run_single(input string name, input op_t o, input mat_in_t x,
                              input mat_in_t y, input elem_t s);
        mat_out_t er;
        int       ed;
        @(negedge clk);
        op     = o;
        a      = x;
        b      = y;
        scalar = s;
        start  = 1'b1;
        er     = model_result(o, x, y, s);
        ed     = model_det(x);
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);            // Wait for the done pulse
        check_outputs(name, er, res_t'(ed), ed == 0, 1'b1);
    endtask

    // Corner values -8 and 7 for the element ops
    task automatic run_extremes(input string name, input op_t o);
        run_single(name, o, 16'h8888, 16'h8888, 4'h8);
        run_single(name, o, 16'h7777, 16'h8888, 4'h7);
        run_single(name, o, 16'h7777, 16'h7777, 4'h8);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        mat_out_t prev_res;
        int       prev_det;
        mat_in_t  x;
        lfsr_state  = 32'h0996e472;
        cycle_count = 0;
        start       = 1'b0;
        op          = OP_ADD;
        a           = '0;
        b           = '0;
        scalar      = '0;

        // Reset values before any start
        @(negedge clk);
        while (reset) @(posedge clk);
        @(negedge clk);
        check_outputs("reset", '0, '0, 1'b0, 1'b0);

        for (int i = 0; i < N_RAND; i++) run_single("add", OP_ADD, rand_mat(), rand_mat(), 0);
        for (int i = 0; i < N_RAND; i++) run_single("sub", OP_SUB, rand_mat(), rand_mat(), 0);
        for (int i = 0; i < N_RAND; i++) begin
            run_single("scale", OP_SCALE, rand_mat(), rand_mat(), rand_elem());
        end
        run_extremes("add_extreme", OP_ADD);
        run_extremes("sub_extreme", OP_SUB);
        run_extremes("scale_extreme", OP_SCALE);

        for (int i = 0; i < N_RAND; i++) run_single("mul", OP_MUL, rand_mat(), rand_mat(), 0);
        for (int i = 0; i < N_RAND; i++) begin
            run_single("transpose", OP_TRANSPOSE, rand_mat(), rand_mat(), 0);
        end

        // Alternate adjugate and determinant on random A
        for (int i = 0; i < N_RAND; i++) begin
            run_single(i % 2 ? "det" : "adj", op_t'(i % 2 ? OP_DET : OP_ADJ),
                       rand_mat(), '0, 0);
        end
        for (int i = 0; i < N_CRAFT; i++) begin
            run_single("adj_singular", OP_ADJ, CRAFT[i], rand_mat(), 0);
            run_single("det_singular", OP_DET, CRAFT[i], rand_mat(), 0);
        end

        // Burst with the op changing every cycle
        for (int i = 0; i < N_BURST; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_outputs("burst", prev_res, res_t'(prev_det), prev_det == 0, 1'b1);
            end
            x      = rand_mat();
            op     = op_t'(i % 7);
            a      = x;
            b      = rand_mat();
            scalar = rand_elem();
            start  = 1'b1;
            prev_res = model_result(op, x, b, scalar);
            prev_det = model_det(x);
        end
        @(negedge clk);
        start = 1'b0;
        check_outputs("burst", prev_res, res_t'(prev_det), prev_det == 0, 1'b1);

        // Outputs must hold while inputs wander with start low
        repeat (3) begin
            a      = rand_mat();
            b      = rand_mat();
            scalar = rand_elem();
            @(negedge clk);
            check_outputs("hold", prev_res, res_t'(prev_det), prev_det == 0, 1'b0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== testbench/matrix_alu_props.sv ====
`timescale 1ns/1ps

module matrix_alu_props
    import matrix_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     start,
    input logic     done,
    input mat_out_t result,
    input res_t     det,
    input logic     singular
);

    // Done mirrors start with one cycle of delay
    done_follows_start: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (done == $past(start))
    ) else $error("done does not follow start by exactly one cycle");

    // Everything cleared in the cycle after reset
    outputs_clear_after_reset: assert property (
        @(posedge clk)
        $past(reset) |-> (!done && !singular && result == '0 && det == '0)
    ) else $error("outputs not cleared after reset");

    // Flag must agree with the registered determinant
    singular_matches_det: assert property (
        @(posedge clk) disable iff (reset)
        done |-> (singular == (det == '0))
    ) else $error("singular flag disagrees with det");

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,                            // 40 ns period
    output logic reset                           // Sync, active high
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                  // Half period
    end

    // Hold reset for 16 rising edges, release on a falling edge
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== verilog/matrix_alu.sv ====
`timescale 1ns/1ps

module matrix_alu
    import matrix_pkg::*;
(
    input  logic     clk,
    input  logic     reset,                      // Sync, active high
    input  logic     start,                      // Strobe, inputs sampled here
    input  op_t      op,                         // Operation select
    input  mat_in_t  a,                          // Matrix A
    input  mat_in_t  b,                          // Matrix B
    input  elem_t    scalar,                     // Scale factor
    output mat_out_t result,                     // Result, one cycle after start
    output res_t     det,                        // Determinant of A
    output logic     singular,                   // A has zero determinant
    output logic     done                        // Result valid pulse
);

    ew_results_t ew;                             // Element-wise candidates
    mat_out_t    product;                        // Matrix product
    res_t        det_val;                        // Combinational determinant
    logic        is_singular;                    // Combinational singular flag
    mat_out_t    adj;                            // Combinational adjugate

    elementwise_unit u_ew (
        .a      (a),
        .b      (b),
        .scalar (scalar),
        .ew     (ew)
    );

    matmul_unit u_mul (
        .a       (a),
        .b       (b),
        .product (product)
    );

    det_adj_unit u_det (
        .a           (a),
        .det_val     (det_val),
        .is_singular (is_singular),
        .adj         (adj)
    );

    // Single register stage, all latency lives here
    result_select u_sel (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .a           (a),
        .ew          (ew),
        .product     (product),
        .det_val     (det_val),
        .is_singular (is_singular),
        .adj         (adj),
        .result      (result),
        .det         (det),
        .singular    (singular),
        .done        (done)
    );

endmodule

// ==== verilog/result_select.sv ====
`timescale 1ns/1ps

module result_select
    import matrix_pkg::*;
(
    input  logic        clk,
    input  logic        reset,                   // Sync, active high
    input  logic        start,                   // One-cycle request strobe
    input  op_t         op,                      // Operation for this start
    input  mat_in_t     a,                       // Raw A for transpose
    input  ew_results_t ew,                      // Sum, diff, scaled
    input  mat_out_t    product,                 // A x B
    input  res_t        det_val,                 // Determinant of A
    input  logic        is_singular,             // det_val == 0
    input  mat_out_t    adj,                     // Adjugate of A
    output mat_out_t    result,                  // Registered matrix result
    output res_t        det,                     // Registered determinant
    output logic        singular,                // Registered singular flag
    output logic        done                     // High the cycle after start
);

    mat_out_t a_w;                               // Widened A
    mat_out_t a_t;                               // Transposed A
    mat_out_t sel;                               // Result chosen by op

    // Transpose is pure routing, no unit needed
    always_comb begin
        a_w     = widen_mat(a);
        a_t     = a_w;
        a_t.m12 = a_w.m21;                       // Swap off-diagonal
        a_t.m21 = a_w.m12;
    end

    // Only place the op code is decoded
    always_comb begin
        case (op)
            OP_ADD:       sel = ew.sum;
            OP_SUB:       sel = ew.diff;
            OP_SCALE:     sel = ew.scaled;
            OP_MUL:       sel = product;
            OP_TRANSPOSE: sel = a_t;
            OP_ADJ:       sel = adj;
            default:      sel = '0;              // OP_DET and unused code
        endcase
    end

    // Done follows start by one cycle, back-to-back keeps it high
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // Output registers load only on start, hold otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            result   <= '0;
            det      <= '0;
            singular <= 1'b0;
        end else if (start) begin
            result   <= sel;
            det      <= det_val;                 // Updated whatever the op
            singular <= is_singular;
        end
    end

endmodule

// ==== verilog/det_adj_unit.sv ====
`timescale 1ns/1ps

module det_adj_unit
    import matrix_pkg::*;
(
    input  mat_in_t  a,                          // Source matrix
    output res_t     det_val,                    // m11*m22 - m12*m21
    output logic     is_singular,                // Determinant is zero
    output mat_out_t adj                         // Adjugate, zeroed when singular
);

    mat_out_t a_w;                               // Widened A
    res_t     diag;                              // Main diagonal product
    res_t     anti;                              // Anti diagonal product

    always_comb begin
        a_w  = widen_mat(a);
        diag = a_w.m11 * a_w.m22;
        anti = a_w.m12 * a_w.m21;
    end

    // Range -120..120, well inside RES_W
    assign det_val     = diag - anti;
    assign is_singular = (det_val == '0);

    // Swap diagonal, negate off-diagonal
    // No inverse exists for a singular A, so report zeros instead
    always_comb begin
        if (is_singular) begin
            adj = '0;                            // Nothing to invert
        end else begin
            adj.m11 = a_w.m22;
            adj.m12 = -a_w.m12;                  // -(-8) = 8 fits after widening
            adj.m21 = -a_w.m21;
            adj.m22 = a_w.m11;
        end
    end

endmodule

// ==== verilog/matmul_unit.sv ====
`timescale 1ns/1ps

module matmul_unit
    import matrix_pkg::*;
(
    input  mat_in_t  a,                          // Left operand
    input  mat_in_t  b,                          // Right operand
    output mat_out_t product                     // A x B
);

    mat_out_t a_w;                               // Widened A
    mat_out_t b_w;                               // Widened B

    always_comb begin
        a_w = widen_mat(a);
        b_w = widen_mat(b);
    end

    // Row of A dot column of B
    // Worst case 64 + 64 = 128, inside the 9-bit signed range
    always_comb begin
        product.m11 = a_w.m11 * b_w.m11          // Row 1, col 1
                    + a_w.m12 * b_w.m21;
        product.m12 = a_w.m11 * b_w.m12          // Row 1, col 2
                    + a_w.m12 * b_w.m22;
        product.m21 = a_w.m21 * b_w.m11          // Row 2, col 1
                    + a_w.m22 * b_w.m21;
        product.m22 = a_w.m21 * b_w.m12          // Row 2, col 2
                    + a_w.m22 * b_w.m22;
    end

endmodule

// ==== verilog/elementwise_unit.sv ====
`timescale 1ns/1ps

module elementwise_unit
    import matrix_pkg::*;
(
    input  mat_in_t     a,                       // Matrix A
    input  mat_in_t     b,                       // Matrix B
    input  elem_t       scalar,                  // Scale factor for A
    output ew_results_t ew                       // Sum, difference, scaled A
);

    mat_out_t a_w;                               // A at result width
    mat_out_t b_w;                               // B at result width
    res_t     s_w;                               // Scalar at result width

    // Widen first so nothing wraps
    always_comb begin
        a_w = widen_mat(a);
        b_w = widen_mat(b);
        s_w = widen(scalar);
    end

    // All three ops in parallel, result_select picks one
    always_comb begin
        ew.sum.m11    = a_w.m11 + b_w.m11;       // Range -16..14
        ew.sum.m12    = a_w.m12 + b_w.m12;
        ew.sum.m21    = a_w.m21 + b_w.m21;
        ew.sum.m22    = a_w.m22 + b_w.m22;

        ew.diff.m11   = a_w.m11 - b_w.m11;       // Range -15..15
        ew.diff.m12   = a_w.m12 - b_w.m12;
        ew.diff.m21   = a_w.m21 - b_w.m21;
        ew.diff.m22   = a_w.m22 - b_w.m22;

        // -8 * -8 = 64 is the largest magnitude
        ew.scaled.m11 = s_w * a_w.m11;
        ew.scaled.m12 = s_w * a_w.m12;
        ew.scaled.m21 = s_w * a_w.m21;
        ew.scaled.m22 = s_w * a_w.m22;
    end

endmodule

// ==== verilog/matrix_pkg.sv ====
package matrix_pkg;

    localparam int ELEM_W = 4;                   // Signed input element width
    localparam int RES_W  = 9;                   // Fits a sum of two 4b x 4b products

    typedef logic signed [ELEM_W-1:0] elem_t;    // One input element
    typedef logic signed [RES_W-1:0]  res_t;     // One widened result element

    // Row-major 2x2 input matrix, m11 in the top bits
    typedef struct packed {
        elem_t m11;                              // Top left
        elem_t m12;                              // Top right
        elem_t m21;                              // Bottom left
        elem_t m22;                              // Bottom right
    } mat_in_t;

    // Same layout at result width
    typedef struct packed {
        res_t m11;
        res_t m12;
        res_t m21;
        res_t m22;
    } mat_out_t;

    typedef enum logic [2:0] {
        OP_ADD       = 3'd0,                     // A + B
        OP_SUB       = 3'd1,                     // A - B
        OP_SCALE     = 3'd2,                     // scalar * A
        OP_MUL       = 3'd3,                     // A x B
        OP_TRANSPOSE = 3'd4,                     // A with m12/m21 swapped
        OP_ADJ       = 3'd5,                     // Adjugate, zero if singular
        OP_DET       = 3'd6                      // Determinant only, zero matrix
    } op_t;

    // All element-wise candidates side by side
    typedef struct packed {
        mat_out_t sum;                           // A + B
        mat_out_t diff;                          // A - B
        mat_out_t scaled;                        // scalar * A
    } ew_results_t;

    // Sign-extend one element to result width
    function automatic res_t widen(input elem_t e);
        res_t w;
        w = e;                                   // Signed source, so sign extends
        return w;
    endfunction

    // Sign-extend a whole matrix
    function automatic mat_out_t widen_mat(input mat_in_t m);
        mat_out_t w;
        w.m11 = widen(m.m11);
        w.m12 = widen(m.m12);
        w.m21 = widen(m.m21);
        w.m22 = widen(m.m22);
        return w;
    endfunction

endpackage
